/* include/lane_defs.svh */
/*
  Lane sizing constants. The bank count must be a power of two, at least
  two, and must divide the register count.
*/
`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

//////////////////////////////////////////////////
// Register file
//////////////////////////////////////////////////

// Architectural registers seen by one lane
`define LANE_NUM_REGS	32

// Even and odd bank, bank = index modulo count
`define LANE_NUM_BANKS	2

//////////////////////////////////////////////////
// Datapath
//////////////////////////////////////////////////

`define LANE_DATA_W		32
`define LANE_IMM_W		16	// Signed, extended to data width

// Issue number from the scalar unit
`define LANE_ISSUE_W	6

`endif

/* verilog/lane_pkg.sv */
/*
  Types shared by the lane datapath. Widths follow lane_defs.svh.
  The opcode encoding is the one the scalar unit issues on cmd_op.
*/
`include "lane_defs.svh"

package lane_pkg;

	// One register value
	typedef logic [`LANE_DATA_W-1:0] data_t;

	// Architectural register index
	typedef logic [$clog2(`LANE_NUM_REGS)-1:0] reg_idx_t;

	// Entry within one bank, register index without its bank bits
	typedef logic [$clog2(`LANE_NUM_REGS / `LANE_NUM_BANKS)-1:0] bank_idx_t;

	typedef logic signed [`LANE_IMM_W-1:0] imm_t;

	typedef logic [`LANE_ISSUE_W-1:0] issue_no_t;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	typedef enum logic [3:0] {
		OP_NOP      = 4'd0,
		OP_ADD      = 4'd1,
		OP_SUB      = 4'd2,
		OP_AND      = 4'd3,
		OP_OR       = 4'd4,
		OP_XOR      = 4'd5,
		OP_ADDI     = 4'd6,	// src1 + imm
		OP_MOVS     = 4'd7,	// From scalar unit
		OP_MVTS     = 4'd8,	// To scalar unit
		OP_LANE_OFF = 4'd9,
		OP_LANE_ON  = 4'd10
	} lane_op_e;

endpackage

/* verilog/lane_ifs.sv */
/*
  Internal buses of the lane. bank_if is instantiated once per bank.
  exec_if is aligned with the registered bank read data.
*/
`timescale 1ns/1ps

// Read and write access to one register bank
interface bank_if;
	import lane_pkg::*;

	bank_idx_t rd_idx1;
	bank_idx_t rd_idx2;
	logic      wr_en;
	bank_idx_t wr_idx;
	data_t     wr_data;
	data_t     rd_data1;
	data_t     rd_data2;

	modport router (output rd_idx1, rd_idx2, wr_en, wr_idx, wr_data);
	modport bank (input rd_idx1, rd_idx2, wr_en, wr_idx, wr_data, output rd_data1, rd_data2);
	modport reader (input rd_data1, rd_data2);
endinterface

// Decoded command in the execute stage
interface exec_if;
	import lane_pkg::*;

	logic      valid;
	lane_op_e  op;
	reg_idx_t  dst;
	reg_idx_t  src1;
	reg_idx_t  src2;
	imm_t      imm;
	issue_no_t issue_no;
	logic      write_allowed;	// Lane was active when sampled

	modport source (output valid, op, dst, src1, src2, imm, issue_no, write_allowed);
	modport operand (input src1, src2);
	modport sink (input valid, op, dst, src1, src2, imm, issue_no, write_allowed);
endinterface

// Write-back register
interface wb_if;
	import lane_pkg::*;

	logic      valid;	// One pulse per command
	logic      write;
	reg_idx_t  dst;
	data_t     data;
	issue_no_t issue_no;

	modport source (output valid, write, dst, data, issue_no);
	modport sink (input valid, write, dst, data, issue_no);
endinterface

/* verilog/lane_decode.sv */
/*
  Command capture and bank routing. One command per cycle, no stall.
  Lane enable changes apply to commands sampled after the controlling one.
*/
`timescale 1ns/1ps
`include "lane_defs.svh"

module lane_decode (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  lane_pkg::lane_op_e   cmd_op,
	input  lane_pkg::reg_idx_t   cmd_dst,
	input  lane_pkg::reg_idx_t   cmd_src1,
	input  lane_pkg::reg_idx_t   cmd_src2,
	input  lane_pkg::imm_t       cmd_imm,
	input  lane_pkg::issue_no_t  cmd_issue_no,
	output logic                 lane_active,
	bank_if.router               banks [`LANE_NUM_BANKS],
	exec_if.source               exe,
	wb_if.sink                   wb
);
	import lane_pkg::*;

	localparam int SEL_W = $clog2(`LANE_NUM_BANKS);
	localparam int IDX_W = $bits(reg_idx_t);

	logic      cmd_q_valid;
	lane_op_e  cmd_q_op;
	reg_idx_t  cmd_q_dst;
	reg_idx_t  cmd_q_src1;
	reg_idx_t  cmd_q_src2;
	imm_t      cmd_q_imm;
	issue_no_t cmd_q_issue_no;
	logic      cmd_q_allowed;

	logic [SEL_W-1:0] src1_sel;
	logic [SEL_W-1:0] src2_sel;
	logic [SEL_W-1:0] wb_sel;

	//////////////////////////////////////////////////
	// Command register and lane enable
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			cmd_q_valid <= 1'b0;
			lane_active <= 1'b1;
		end else begin
			cmd_q_valid <= cmd_valid;
			if (cmd_valid && cmd_op == OP_LANE_OFF)
				lane_active <= 1'b0;
			else if (cmd_valid && cmd_op == OP_LANE_ON)
				lane_active <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		cmd_q_op       <= cmd_op;
		cmd_q_dst      <= cmd_dst;
		cmd_q_src1     <= cmd_src1;
		cmd_q_src2     <= cmd_src2;
		cmd_q_imm      <= cmd_imm;
		cmd_q_issue_no <= cmd_issue_no;
		cmd_q_allowed  <= lane_active;	// Flag before this command
	end

	//////////////////////////////////////////////////
	// Bank routing
	//////////////////////////////////////////////////

	assign src1_sel = cmd_q_src1[SEL_W-1:0];
	assign src2_sel = cmd_q_src2[SEL_W-1:0];
	assign wb_sel   = wb.dst[SEL_W-1:0];

	for (genvar g = 0; g < `LANE_NUM_BANKS; g++) begin : g_route
		// Source 1 on read port 1, source 2 on read port 2
		assign banks[g].rd_idx1 = (src1_sel == SEL_W'(g)) ? cmd_q_src1[IDX_W-1:SEL_W] : '0;
		assign banks[g].rd_idx2 = (src2_sel == SEL_W'(g)) ? cmd_q_src2[IDX_W-1:SEL_W] : '0;

		assign banks[g].wr_en   = wb.valid && wb.write && (wb_sel == SEL_W'(g));
		assign banks[g].wr_idx  = wb.dst[IDX_W-1:SEL_W];
		assign banks[g].wr_data = wb.data;
	end

	// Execute stage, lines up with the bank read data
	always_ff @(posedge clock) begin
		if (reset)
			exe.valid <= 1'b0;
		else
			exe.valid <= cmd_q_valid;
	end

	always_ff @(posedge clock) begin
		exe.op            <= cmd_q_op;
		exe.dst           <= cmd_q_dst;
		exe.src1          <= cmd_q_src1;
		exe.src2          <= cmd_q_src2;
		exe.imm           <= cmd_q_imm;
		exe.issue_no      <= cmd_q_issue_no;
		exe.write_allowed <= cmd_q_allowed;
	end

endmodule

/* verilog/reg_bank.sv */
/*
  One register bank, two registered read ports and one write port.
  A read of the entry being written returns the new data.
*/
`timescale 1ns/1ps
`include "lane_defs.svh"

module reg_bank (
	input logic  clock,
	input logic  reset,
	bank_if.bank port
);
	import lane_pkg::*;

	localparam int DEPTH = `LANE_NUM_REGS / `LANE_NUM_BANKS;

	data_t mem [DEPTH];

	// Registers start at zero
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (port.wr_en) begin
			mem[port.wr_idx] <= port.wr_data;
		end
	end

	//////////////////////////////////////////////////
	// Read ports, write-first
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (port.wr_en && port.wr_idx == port.rd_idx1)
			port.rd_data1 <= port.wr_data;
		else
			port.rd_data1 <= mem[port.rd_idx1];

		if (port.wr_en && port.wr_idx == port.rd_idx2)
			port.rd_data2 <= port.wr_data;
		else
			port.rd_data2 <= mem[port.rd_idx2];
	end

endmodule

/* verilog/operand_select.sv */
/*
  Picks both operands from the bank of their register and forwards the
  result held in write-back, which reaches the bank one edge later.
*/
`timescale 1ns/1ps
`include "lane_defs.svh"

module operand_select (
	bank_if.reader           banks [`LANE_NUM_BANKS],
	exec_if.operand          exe,
	wb_if.sink               wb,
	output lane_pkg::data_t  src1_data,
	output lane_pkg::data_t  src2_data
);
	import lane_pkg::*;

	localparam int SEL_W = $clog2(`LANE_NUM_BANKS);

	data_t port1_data [`LANE_NUM_BANKS];
	data_t port2_data [`LANE_NUM_BANKS];
	logic  fwd1;
	logic  fwd2;

	// Read data of every bank, by bank number
	for (genvar g = 0; g < `LANE_NUM_BANKS; g++) begin : g_gather
		assign port1_data[g] = banks[g].rd_data1;
		assign port2_data[g] = banks[g].rd_data2;
	end

	//////////////////////////////////////////////////
	// Forwarding from write-back
	//////////////////////////////////////////////////

	assign fwd1 = wb.valid && wb.write && (wb.dst == exe.src1);
	assign fwd2 = wb.valid && wb.write && (wb.dst == exe.src2);

	assign src1_data = fwd1 ? wb.data : port1_data[exe.src1[SEL_W-1:0]];
	assign src2_data = fwd2 ? wb.data : port2_data[exe.src2[SEL_W-1:0]];

endmodule

/* verilog/lane_alu.sv */
/*
  Integer execute stage with the write-back and scalar-out registers.
  Every valid command gives one write-back pulse, written or not.
  Commands taken while the lane was off touch neither register file nor scalar_out.
*/
`timescale 1ns/1ps

module lane_alu (
	input  logic             clock,
	input  logic             reset,
	exec_if.sink             exe,
	input  lane_pkg::data_t  src1_data,
	input  lane_pkg::data_t  src2_data,
	input  lane_pkg::data_t  scalar_in,
	output lane_pkg::data_t  scalar_out,
	wb_if.source             wb
);
	import lane_pkg::*;

	data_t result;
	logic  has_result;
	logic  exec_ok;

	//////////////////////////////////////////////////
	// Operation
	//////////////////////////////////////////////////

	always_comb begin
		result     = '0;
		has_result = 1'b1;
		case (exe.op)
			OP_ADD:  result = src1_data + src2_data;
			OP_SUB:  result = src1_data - src2_data;
			OP_AND:  result = src1_data & src2_data;
			OP_OR:   result = src1_data | src2_data;
			OP_XOR:  result = src1_data ^ src2_data;
			OP_ADDI: result = src1_data + data_t'(exe.imm);	// Sign extended
			OP_MOVS: result = scalar_in;
			default: has_result = 1'b0;	// NOP, MVTS, lane control
		endcase
	end

	assign exec_ok = exe.valid && exe.write_allowed;

	//////////////////////////////////////////////////
	// Write-back and scalar out
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid   <= 1'b0;
			wb.write   <= 1'b0;
			scalar_out <= '0;
		end else begin
			wb.valid <= exe.valid;
			wb.write <= exec_ok && has_result;
			if (exec_ok && exe.op == OP_MVTS) begin
				scalar_out <= src1_data;
			end
		end
	end

	// Payload follows the command
	always_ff @(posedge clock) begin
		wb.dst      <= exe.dst;
		wb.data     <= result;
		wb.issue_no <= exe.issue_no;
	end

endmodule

/* verilog/lane_unit.sv */
/*
  One SIMT lane. A command is a one-cycle strobe, one may come every cycle.
  Commit follows the command by three clock edges, in issue order.
*/
`timescale 1ns/1ps
`include "lane_defs.svh"

module lane_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 cmd_valid,
	input  lane_pkg::lane_op_e   cmd_op,
	input  lane_pkg::reg_idx_t   cmd_dst,
	input  lane_pkg::reg_idx_t   cmd_src1,
	input  lane_pkg::reg_idx_t   cmd_src2,
	input  lane_pkg::imm_t       cmd_imm,
	input  lane_pkg::issue_no_t  cmd_issue_no,
	input  lane_pkg::data_t      scalar_in,
	output lane_pkg::data_t      scalar_out,
	output logic                 lane_active,
	output logic                 commit_valid,
	output lane_pkg::issue_no_t  commit_no
);
	import lane_pkg::*;

	bank_if banks [`LANE_NUM_BANKS] ();
	exec_if exe ();
	wb_if   wb ();

	data_t src1_data;
	data_t src2_data;

	lane_decode u_decode (
		.clock        (clock),
		.reset        (reset),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_dst      (cmd_dst),
		.cmd_src1     (cmd_src1),
		.cmd_src2     (cmd_src2),
		.cmd_imm      (cmd_imm),
		.cmd_issue_no (cmd_issue_no),
		.lane_active  (lane_active),
		.banks        (banks),
		.exe          (exe),
		.wb           (wb)
	);

	//////////////////////////////////////////////////
	// Register file, even and odd bank
	//////////////////////////////////////////////////

	for (genvar g = 0; g < `LANE_NUM_BANKS; g++) begin : g_bank
		reg_bank u_bank (
			.clock (clock),
			.reset (reset),
			.port  (banks[g])
		);
	end

	operand_select u_opsel (
		.banks     (banks),
		.exe       (exe),
		.wb        (wb),
		.src1_data (src1_data),
		.src2_data (src2_data)
	);

	lane_alu u_alu (
		.clock      (clock),
		.reset      (reset),
		.exe        (exe),
		.src1_data  (src1_data),
		.src2_data  (src2_data),
		.scalar_in  (scalar_in),
		.scalar_out (scalar_out),
		.wb         (wb)
	);

	// In order, so commit comes straight from write-back
	assign commit_valid = wb.valid;
	assign commit_no    = wb.issue_no;

endmodule

/* sim/lane_clock_gen.sv */
/*
  Free-running testbench clock, starts low.
*/
`timescale 1ns/1ps

module lane_clock_gen #(
	parameter realtime PERIOD = 4.0
) (
	output logic clock
);
	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end
endmodule

/* sim/lane_unit_assertions.sv */
/*
  Checks bound into lane_unit. Only two bank write enables are watched,
  so the bank count is assumed to be two.
*/
`timescale 1ns/1ps

module lane_unit_assertions (
	input logic clock,
	input logic reset,
	input logic cmd_valid,
	input logic commit_valid,
	input logic bank0_wr_en,
	input logic bank1_wr_en
);
	int assert_fails = 0;

	commit_known: assert property (
		@(posedge clock) disable iff (reset) !$isunknown(commit_valid)
	) else begin
		assert_fails++;
		$error("commit_valid is unknown out of reset");
	end

	// First reset edge still sees power-up state
	no_write_in_reset: assert property (
		@(posedge clock) (reset && $past(reset)) |-> !(bank0_wr_en || bank1_wr_en)
	) else begin
		assert_fails++;
		$error("bank write enabled during reset");
	end

	//////////////////////////////////////////////////
	// Commit timing
	//////////////////////////////////////////////////

	commit_after_cmd: assert property (
		@(posedge clock) disable iff (reset) cmd_valid |-> ##3 commit_valid
	) else begin
		assert_fails++;
		$error("command not committed three cycles later");
	end

	commit_has_cmd: assert property (
		@(posedge clock) disable iff (reset) commit_valid |-> $past(cmd_valid, 3)
	) else begin
		assert_fails++;
		$error("commit without a command three cycles earlier");
	end
endmodule

bind lane_unit lane_unit_assertions assertions_i (
	.clock        (clock),
	.reset        (reset),
	.cmd_valid    (cmd_valid),
	.commit_valid (commit_valid),
	.bank0_wr_en  (banks[0].wr_en),
	.bank1_wr_en  (banks[1].wr_en)
);

/* sim/lane_unit_tb.sv */
/*
  Testbench for lane_unit. Commands come from a table, one per cycle, with
  idle gaps between tests. A reference model predicts commits and scalar_out.
*/
`timescale 1ns/1ps
`include "lane_defs.svh"

module lane_unit_tb;
	import lane_pkg::*;

	localparam int NUM_TESTS   = 3;
	localparam int IDLE_CYCLES = 5;
	localparam int CLK_NS      = 4;

	typedef struct {
		int       test;
		lane_op_e op;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t     imm;
		bit       check;	// Compare scalar_out at commit
	} row_t;

	typedef struct {
		int        test;
		issue_no_t issue_no;
		data_t     scalar;
		bit        check;
		time       due;
	} commit_t;

	logic      clock;
	logic      reset;
	logic      cmd_valid;
	lane_op_e  cmd_op;
	reg_idx_t  cmd_dst;
	reg_idx_t  cmd_src1;
	reg_idx_t  cmd_src2;
	imm_t      cmd_imm;
	issue_no_t cmd_issue_no;
	data_t     scalar_in;
	data_t     scalar_out;
	logic      lane_active;
	logic      commit_valid;
	issue_no_t commit_no;

	row_t      rows [$];
	commit_t   expected [$];
	data_t     model_regs [`LANE_NUM_REGS];
	logic      model_active;
	data_t     model_scalar;
	data_t     scalar_d0;
	data_t     scalar_d1;
	issue_no_t issue_ctr;
	int        cur_test;
	int        checks;
	int        test_errs [NUM_TESTS+1];
	bit        table_built;

	lane_clock_gen clock_gen_i (.clock(clock));

	lane_unit dut_i (.*);

	task automatic add_row(input int test, input lane_op_e op, input reg_idx_t dst,
			input reg_idx_t src1, input reg_idx_t src2, input imm_t imm, input bit check);
		rows.push_back(row_t'{test, op, dst, src1, src2, imm, check});
	endtask

	task automatic build_table();
		// Dependent chain, odd and even banks
		add_row(1, OP_MOVS, 1, 0, 0, 0, 0);
		add_row(1, OP_MOVS, 2, 0, 0, 0, 0);
		add_row(1, OP_ADD, 3, 1, 2, 0, 0);
		add_row(1, OP_SUB, 5, 3, 1, 0, 0);
		add_row(1, OP_XOR, 4, 5, 2, 0, 0);
		add_row(1, OP_AND, 6, 4, 3, 0, 0);
		add_row(1, OP_OR, 8, 6, 4, 0, 0);
		add_row(1, OP_ADD, 8, 8, 8, 0, 0);
		add_row(1, OP_MVTS, 0, 8, 0, 0, 1);
		add_row(1, OP_MVTS, 0, 5, 0, 0, 1);
		add_row(1, OP_MVTS, 0, 6, 0, 0, 1);
		// Immediates, two apart hits the write-first read
		add_row(2, OP_MOVS, 12, 0, 0, 0, 0);
		add_row(2, OP_ADDI, 10, 0, 0, -5, 0);
		add_row(2, OP_ADDI, 13, 12, 0, 1234, 0);
		add_row(2, OP_ADDI, 11, 10, 0, -32768, 0);
		add_row(2, OP_MVTS, 0, 10, 0, 0, 1);
		add_row(2, OP_MVTS, 0, 11, 0, 0, 1);
		add_row(2, OP_MVTS, 0, 12, 0, 0, 1);
		add_row(2, OP_MVTS, 0, 13, 0, 0, 1);
		// Lane off and back on
		add_row(3, OP_LANE_OFF, 0, 0, 0, 0, 0);
		add_row(3, OP_MOVS, 1, 0, 0, 0, 0);
		add_row(3, OP_ADDI, 3, 3, 0, 7, 0);
		add_row(3, OP_MVTS, 0, 1, 0, 0, 1);
		add_row(3, OP_LANE_ON, 0, 0, 0, 0, 0);
		add_row(3, OP_MVTS, 0, 1, 0, 0, 1);
		add_row(3, OP_MVTS, 0, 3, 0, 0, 1);
	endtask

	task automatic report_mismatch(input int test, input string what, input logic [63:0] got,
			input logic [63:0] exp);
		$display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
		test_errs[test]++;
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	task automatic apply_model(input row_t r, input data_t sval);
		data_t a;
		data_t b;
		data_t res;
		bit    has_res;
		a = model_regs[r.src1];
		b = model_regs[r.src2];
		res = '0;
		has_res = 1'b1;
		case (r.op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_AND:  res = a & b;
			OP_OR:   res = a | b;
			OP_XOR:  res = a ^ b;
			OP_ADDI: res = a + {{(`LANE_DATA_W-`LANE_IMM_W){r.imm[`LANE_IMM_W-1]}}, r.imm};
			OP_MOVS: res = sval;
			default: has_res = 1'b0;
		endcase
		if (model_active && has_res)
			model_regs[r.dst] = res;
		if (model_active && r.op == OP_MVTS)
			model_scalar = a;
		if (r.op == OP_LANE_OFF)
			model_active = 1'b0;
		else if (r.op == OP_LANE_ON)
			model_active = 1'b1;
	endtask

	task automatic drive_cycle(input bit valid, input row_t r, input data_t sval);
		@(negedge clock);
		checks++;
		if (lane_active !== model_active)
			report_mismatch(cur_test, "lane_active", lane_active, model_active);
		// Execute samples scalar_in two cycles after the command
		scalar_in = scalar_d1;
		scalar_d1 = scalar_d0;
		scalar_d0 = sval;
		cmd_valid    = valid;
		cmd_op       = r.op;
		cmd_dst      = r.dst;
		cmd_src1     = r.src1;
		cmd_src2     = r.src2;
		cmd_imm      = r.imm;
		cmd_issue_no = issue_ctr;
		if (valid) begin
			apply_model(r, sval);
			expected.push_back(commit_t'{r.test, issue_ctr, model_scalar, r.check,
				$time + 3 * CLK_NS});
			issue_ctr++;
		end
	endtask

	task automatic report_test(input int t);
		$display("test %0d %s, %0d errors", t, (test_errs[t] == 0) ? "passed" : "FAILED",
			test_errs[t]);
	endtask

	// Commit monitor
	always @(negedge clock) begin
		commit_t c;
		if (!reset && commit_valid) begin
			if (expected.size() == 0) begin
				$display("ERROR at %0t: commit seen with no command outstanding", $time);
				test_errs[cur_test]++;
			end else begin
				c = expected.pop_front();
				checks++;
				if (commit_no !== c.issue_no)
					report_mismatch(c.test, "commit_no", commit_no, c.issue_no);
				if ($time != c.due) begin
					$display("ERROR at %0t: issue %0d committed off time, due at %0t",
						$time, c.issue_no, c.due);
					test_errs[c.test]++;
				end
				if (c.check && scalar_out !== c.scalar)
					report_mismatch(c.test, "scalar_out", scalar_out, c.scalar);
			end
		end
	end

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		int   seed;
		int   r_i;
		int   errors;
		row_t idle;
		seed = 56179;
		idle = row_t'{0, OP_NOP, '0, '0, '0, '0, 1'b0};
		reset        = 1'b1;
		cmd_valid    = 1'b0;
		cmd_op       = OP_NOP;
		cmd_dst      = '0;
		cmd_src1     = '0;
		cmd_src2     = '0;
		cmd_imm      = '0;
		cmd_issue_no = '0;
		scalar_in    = '0;
		scalar_d0    = '0;
		scalar_d1    = '0;
		issue_ctr    = '0;
		model_active = 1'b1;
		model_scalar = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		build_table();
		table_built = 1'b1;
		repeat (2) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		cur_test = 0;	// Reset state
		checks += 3;
		if (lane_active !== 1'b1)
			report_mismatch(0, "lane_active", lane_active, 1);
		if (commit_valid !== 1'b0)
			report_mismatch(0, "commit_valid", commit_valid, 0);
		if (scalar_out !== '0)
			report_mismatch(0, "scalar_out", scalar_out, 0);
		report_test(0);

		r_i = 0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			cur_test = t;
			while (r_i < rows.size() && rows[r_i].test == t) begin
				drive_cycle(1'b1, rows[r_i], $random(seed));
				r_i++;
			end
			repeat (IDLE_CYCLES)
				drive_cycle(1'b0, idle, '0);
			report_test(t);
		end

		if (expected.size() != 0) begin
			$display("ERROR: %0d commands never committed", expected.size());
			test_errs[NUM_TESTS]++;
		end
		errors = dut_i.assertions_i.assert_fails;
		foreach (test_errs[i])
			errors += test_errs[i];
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial begin
		wait (table_built);
		#((rows.size() + NUM_TESTS * IDLE_CYCLES + 20) * CLK_NS);
		$display("Timeout: the watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

/* build.f */
+incdir+include
verilog/lane_pkg.sv
verilog/lane_ifs.sv
verilog/lane_decode.sv
verilog/reg_bank.sv
verilog/operand_select.sv
verilog/lane_alu.sv
verilog/lane_unit.sv
sim/lane_clock_gen.sv
sim/lane_unit_assertions.sv
sim/lane_unit_tb.sv
